//--- src/ping_pong_ctrl.sv
/*
 * Ping-pong controller for the west and north operand memories of the
 * systolic array. One bank of each pair fills while the other drains.
 */
`timescale 1ns/100ps

module ping_pong_ctrl
    import pp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic        systolic_finish,
    input  logic        acc_done,
    output w_bank_t     w_bank0,
    output w_bank_t     w_bank1,
    output n_bank_t     n_bank0,
    output n_bank_t     n_bank1,
    output slice_idx_t  slice_idx,
    output buf_status_t status
);

    localparam w_bank_t W_WE_MASK = '{we_a: 1'b1, we_b: 1'b1, default: '0};
    localparam n_bank_t N_WE_MASK = '{we_a: 1'b1, default: '0};

    fill_view_t  fill_view;
    drain_view_t drain_view;
    logic        fill_done;
    logic        fill_blocked;
    logic        drain_start;
    logic        draining;
    logic        drain_done;
    logic        write_bank;

    // Per-operand views built from the generator outputs
    w_bank_t w_wr_view;
    w_bank_t w_rd_view;
    n_bank_t n_wr_view;
    n_bank_t n_rd_view;

    // West writes both rows at once
    assign w_wr_view = '{we_a: fill_view.we, we_b: fill_view.we,
                         addr_a: fill_view.addr_a, addr_b: fill_view.addr_b};
    assign w_rd_view = '{we_a: 1'b0, we_b: 1'b0,
                         addr_a: drain_view.w_addr_a, addr_b: drain_view.w_addr_b};
    // North writes on A and reads on B, the idle port sits at 0
    assign n_wr_view = '{we_a: fill_view.we, addr_a: fill_view.addr_a, addr_b: '0};
    assign n_rd_view = '{we_a: 1'b0, addr_a: '0, addr_b: drain_view.n_addr_b};

    assign slice_idx = fill_view.slice_idx;
    assign status    = '{write_bank: write_bank, draining: draining,
                         fill_blocked: fill_blocked};

    pp_fill_gen fill_gen_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .fill_blocked (fill_blocked),
        .fill_view    (fill_view),
        .fill_done    (fill_done)
    );

    pp_drain_gen drain_gen_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .drain_start     (drain_start),
        .systolic_finish (systolic_finish),
        .acc_done        (acc_done),
        .drain_view      (drain_view),
        .draining        (draining),
        .drain_done      (drain_done)
    );

    pp_bank_sel bank_sel_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill_done    (fill_done),
        .drain_done   (drain_done),
        .draining     (draining),
        .write_bank   (write_bank),
        .drain_start  (drain_start),
        .fill_blocked (fill_blocked)
    );

    pp_bank_route #(.bank_t(w_bank_t), .WE_MASK(W_WE_MASK)) w_route_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .write_bank (write_bank),
        .wr_view    (w_wr_view),
        .rd_view    (w_rd_view),
        .bank0      (w_bank0),
        .bank1      (w_bank1)
    );

    pp_bank_route #(.bank_t(n_bank_t), .WE_MASK(N_WE_MASK)) n_route_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .write_bank (write_bank),
        .wr_view    (n_wr_view),
        .rd_view    (n_rd_view),
        .bank0      (n_bank0),
        .bank1      (n_bank1)
    );

endmodule

//--- src/pp_bank_route.sv
/*
 * Registered router for one operand's two banks. The filling bank gets
 * the write view, the other one the read view.
 * Instantiated once per operand with that operand's bank type.
 */
`timescale 1ns/100ps

module pp_bank_route #(
    parameter type   bank_t  = logic [7:0],
    // Bits of bank_t that are write enables
    parameter bank_t WE_MASK = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  write_bank,
    input  bank_t wr_view,
    input  bank_t rd_view,
    output bank_t bank0,
    output bank_t bank1
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank0 <= '0;
            bank1 <= '0;
        end else begin
            if (write_bank) begin
                // Bank 1 fills while bank 0 drains
                bank0 <= rd_view;
                bank1 <= wr_view;
            end else begin
                bank0 <= wr_view;
                bank1 <= rd_view;
            end
        end
    end

    // Only one bank per operand is written in any cycle
    property p_single_writer;
        @(posedge clk) disable iff (!rst_n)
        !((|(bank0 & WE_MASK)) && (|(bank1 & WE_MASK)));
    endproperty

    a_single_writer: assert property (p_single_writer)
        else $error("both banks have a write enable high");

endmodule

//--- src/pp_bank_sel.sv
/*
 * Bank role tracker. Swaps the filling bank once a fill is complete
 * and no drain is running, and blocks further fills while it waits.
 */
`timescale 1ns/100ps

module pp_bank_sel (
    input  logic clk,
    input  logic rst_n,
    input  logic fill_done,
    input  logic drain_done,
    input  logic draining,
    output logic write_bank,
    output logic drain_start,
    output logic fill_blocked
);

    // A full bank is waiting for the other one to drain
    logic swap_pending;
    logic swap_now;

    // Swap right away when idle, else when the running drain ends
    assign swap_now = (fill_done && !draining) || (swap_pending && drain_done);

    // Drain of the just-filled bank starts on the same edge as the swap
    assign drain_start = swap_now;

    // Also blocks the cycle in which fill_done finds a drain running
    assign fill_blocked = swap_pending || (fill_done && draining);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_bank   <= 1'b0;
            swap_pending <= 1'b0;
        end else begin
            if (swap_now) begin
                write_bank   <= ~write_bank;
                swap_pending <= 1'b0;
            end else if (fill_done) begin
                swap_pending <= 1'b1;
            end
        end
    end

    // Bank being read must keep its role until its drain has finished
    property p_no_flip_while_draining;
        @(posedge clk) disable iff (!rst_n)
        !$stable(write_bank) |-> $past(!draining);
    endproperty

    a_no_flip_while_draining: assert property (p_no_flip_while_draining)
        else $error("write_bank flipped during a drain");

endmodule

//--- src/pp_drain_gen.sv
/*
 * Read-side sequencer for the draining bank. systolic_finish steps the
 * inner block, a rising acc_done steps the output column. The drain
 * ends after PP_COL_Y columns with a drain_done pulse.
 */
`timescale 1ns/100ps
`include "pp_macros.svh"

module pp_drain_gen
    import pp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        drain_start,
    input  logic        systolic_finish,
    input  logic        acc_done,
    output drain_view_t drain_view,
    output logic        draining,
    output logic        drain_done
);

    localparam int K_W   = (`PP_INNER_BLOCKS > 1) ? $clog2(`PP_INNER_BLOCKS) : 1;
    localparam int COL_W = (`PP_COL_Y > 1) ? $clog2(`PP_COL_Y) : 1;

    // Inner block and output column counters
    logic [K_W-1:0]   k;
    logic [COL_W-1:0] col;

    // acc_done delayed by one cycle for the edge detect
    logic acc_done_d;
    logic acc_rise;

    assign acc_rise = acc_done && !acc_done_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            k          <= '0;
            col        <= '0;
            acc_done_d <= 1'b0;
            draining   <= 1'b0;
            drain_done <= 1'b0;
            drain_view <= '0;
        end else begin
            acc_done_d <= acc_done;
            drain_done <= 1'b0;

            if (drain_start) begin
                // New bank, restart from block 0 of column 0
                draining <= 1'b1;
                k        <= '0;
                col      <= '0;
            end else if (draining) begin
                if (systolic_finish) begin
                    // West rows 0 and 1 sit one block row apart
                    drain_view.w_addr_a <= addr_t'(k);
                    drain_view.w_addr_b <= addr_t'(`PP_INNER_BLOCKS) + addr_t'(k);
                    // North moves one block row per output column
                    drain_view.n_addr_b <= addr_t'(`PP_INNER_BLOCKS) * addr_t'(col)
                                           + addr_t'(k);

                    if (k == K_W'(`PP_INNER_BLOCKS - 1)) begin
                        k <= '0;
                    end else begin
                        k <= k + 1'b1;
                    end
                end

                // Only the edge counts, a held acc_done steps once
                if (acc_rise) begin
                    if (col == COL_W'(`PP_COL_Y - 1)) begin
                        col        <= '0;
                        draining   <= 1'b0;
                        drain_done <= 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

    // Bank selector may only start a drain once the previous one has ended
    property p_no_restart;
        @(posedge clk) disable iff (!rst_n)
        drain_start |-> !draining;
    endproperty

    a_no_restart: assert property (p_no_restart)
        else $error("drain_start while a drain is running");

endmodule

//--- src/pp_fill_gen.sv
/*
 * Write-side slice counter. Every accepted in_valid produces one
 * registered write of a slice and a fill_done pulse on the last one.
 */
`timescale 1ns/100ps
`include "pp_macros.svh"

module pp_fill_gen
    import pp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       fill_blocked,
    output fill_view_t fill_view,
    output logic       fill_done
);

    // Index of the slice that the next accepted pulse writes
    slice_idx_t count;
    logic       accept;
    logic       last_slice;

    // Pulses arriving while blocked are dropped and never queued
    assign accept     = in_valid && !fill_blocked;
    assign last_slice = (count == slice_idx_t'(`PP_FILL_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count     <= '0;
            fill_view <= '0;
            fill_done <= 1'b0;
        end else begin
            // Write enable is a single-cycle strobe per pulse
            fill_view.we <= accept;
            fill_done    <= 1'b0;

            if (accept) begin
                // Port A takes the row-0 slot
                fill_view.addr_a    <= addr_t'(count);
                // Port B takes the row-1 slot one fill depth higher
                fill_view.addr_b    <= addr_t'(`PP_FILL_DEPTH) + addr_t'(count);
                fill_view.slice_idx <= count;

                if (last_slice) begin
                    count     <= '0;
                    fill_done <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // The bank selector blocks only once the last slice is written,
    // so the only write seen under a block is that last slice
    property p_no_write_when_blocked;
        @(posedge clk) disable iff (!rst_n)
        fill_blocked |-> (!fill_view.we || fill_done);
    endproperty

    a_no_write_when_blocked: assert property (p_no_write_when_blocked)
        else $error("slice written while fill is blocked");

endmodule

//--- src/pp_macros.svh
/*
 * Sizing constants for the ping-pong operand buffer controller.
 * Included by the package and by the address generators.
 */
`ifndef PP_MACROS_SVH
`define PP_MACROS_SVH

// Address width of every operand memory port
`define PP_ADDR_WIDTH 4

// Slices written per fill, west port B starts this far above port A
`define PP_FILL_DEPTH 4

// Number of input slices per operand word
`define PP_TOTAL_MODULES 4

// Inner-dimension blocks accumulated per output element
`define PP_INNER_BLOCKS 4

// Output columns produced from one drained bank
`define PP_COL_Y 2

// Width of the slice index, log2 of PP_TOTAL_MODULES
`define PP_IDX_WIDTH 2

`endif

//--- src/pp_pkg.sv
/*
 * Shared types of the ping-pong controller. Bank port bundles,
 * the write and read views of the generators, and the status word.
 */
`include "pp_macros.svh"

package pp_pkg;

    // Memory address and slice index
    typedef logic [`PP_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`PP_IDX_WIDTH-1:0]  slice_idx_t;

    // West bank, both ports write during fill and read during drain
    typedef struct packed {
        logic  we_a;
        logic  we_b;
        addr_t addr_a;
        addr_t addr_b;
    } w_bank_t;

    // North bank, port A only writes and port B only reads
    typedef struct packed {
        logic  we_a;
        addr_t addr_a;
        addr_t addr_b;
    } n_bank_t;

    // Registered write side from the fill generator
    typedef struct packed {
        logic       we;
        addr_t      addr_a;
        addr_t      addr_b;
        slice_idx_t slice_idx;
    } fill_view_t;

    // Registered read addresses from the drain generator
    typedef struct packed {
        addr_t w_addr_a;
        addr_t w_addr_b;
        addr_t n_addr_b;
    } drain_view_t;

    // Buffer state as seen from outside
    typedef struct packed {
        logic write_bank;
        logic draining;
        logic fill_blocked;
    } buf_status_t;

endpackage

//--- verif/tb_clk_gen.sv
/*
 * Clock and reset source for the testbench. 4 ns clock, reset held
 * low over the first two rising edges.
 */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a rising edge like every other DUT input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verif/tb_ping_pong_ctrl.sv
/*
 * Directed testbench for the ping-pong controller. Runs reset, a first
 * fill, swap and drain, a blocked fill and a held acc_done in sequence.
 */
`timescale 1ns/100ps
`include "pp_macros.svh"

module tb_ping_pong_ctrl
    import pp_pkg::*;
();

    // All tests take under 100 cycles, four times that is the limit
    localparam int MAX_CYCLES = 400;
    localparam int INNER      = `PP_INNER_BLOCKS;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        systolic_finish;
    logic        acc_done;
    w_bank_t     w_bank0;
    w_bank_t     w_bank1;
    n_bank_t     n_bank0;
    n_bank_t     n_bank1;
    slice_idx_t  slice_idx;
    buf_status_t status;

    integer seed = 32'h1a3996bb;
    int     err_count = 0;
    int     test_start_errs = 0;
    int     cycle_count = 0;
    // Expected read position in the draining bank
    int     drain_bank;
    int     exp_k;
    int     exp_col;

    tb_clk_gen clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ping_pong_ctrl ping_pong_ctrl_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .systolic_finish (systolic_finish),
        .acc_done        (acc_done),
        .w_bank0         (w_bank0),
        .w_bank1         (w_bank1),
        .n_bank0         (n_bank0),
        .n_bank1         (n_bank1),
        .slice_idx       (slice_idx),
        .status          (status)
    );

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d mismatches", name, err_count - test_start_errs);
        test_start_errs = err_count;
    endtask

    task automatic expect_status(input logic wb, input logic dr, input logic fb);
        check("status.write_bank", status.write_bank, wb);
        check("status.draining", status.draining, dr);
        check("status.fill_blocked", status.fill_blocked, fb);
    endtask

    task automatic random_gap();
        repeat ($unsigned($random(seed)) % 4) @(posedge clk);
    endtask

    // One in_valid pulse, write expected two edges after it is driven
    task automatic send_slice(input int idx, input bit expect_write, input bit bank);
        w_bank_t w_wr;
        w_bank_t w_rd;
        n_bank_t n_wr;
        n_bank_t n_rd;
        @(posedge clk);
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        // Still inside the fill generator, no bank written yet
        @(negedge clk);
        check("w_bank0.we_a", w_bank0.we_a, 1'b0);
        check("w_bank1.we_a", w_bank1.we_a, 1'b0);
        check("slice_idx", slice_idx, idx);
        @(negedge clk);
        w_wr = bank ? w_bank1 : w_bank0;
        w_rd = bank ? w_bank0 : w_bank1;
        n_wr = bank ? n_bank1 : n_bank0;
        n_rd = bank ? n_bank0 : n_bank1;
        check($sformatf("w_bank%0d.we_a", bank), w_wr.we_a, expect_write);
        check($sformatf("w_bank%0d.we_b", bank), w_wr.we_b, expect_write);
        check($sformatf("n_bank%0d.we_a", bank), n_wr.we_a, expect_write);
        if (expect_write) begin
            check($sformatf("w_bank%0d.addr_a", bank), w_wr.addr_a, idx);
            check($sformatf("w_bank%0d.addr_b", bank), w_wr.addr_b, `PP_FILL_DEPTH + idx);
            check($sformatf("n_bank%0d.addr_a", bank), n_wr.addr_a, idx);
        end
        // Other bank of each pair stays read-only
        check($sformatf("w_bank%0d.we", !bank), w_rd.we_a | w_rd.we_b, 1'b0);
        check($sformatf("n_bank%0d.we_a", !bank), n_rd.we_a, 1'b0);
    endtask

    // One systolic_finish, read addresses k, INNER+k and INNER*col+k
    task automatic step_block();
        w_bank_t w_rd;
        n_bank_t n_rd;
        @(posedge clk);
        systolic_finish <= 1'b1;
        @(posedge clk);
        systolic_finish <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        w_rd = drain_bank ? w_bank1 : w_bank0;
        n_rd = drain_bank ? n_bank1 : n_bank0;
        check($sformatf("w_bank%0d.addr_a", drain_bank), w_rd.addr_a, exp_k);
        check($sformatf("w_bank%0d.addr_b", drain_bank), w_rd.addr_b, INNER + exp_k);
        check($sformatf("n_bank%0d.addr_b", drain_bank), n_rd.addr_b,
              INNER * exp_col + exp_k);
        check($sformatf("w_bank%0d.we", drain_bank), w_rd.we_a | w_rd.we_b, 1'b0);
        exp_k = (exp_k + 1) % INNER;
    endtask

    // acc_done held for some edges, ends on the negedge after the first one when hold is 1
    task automatic step_column(input int hold);
        @(posedge clk);
        acc_done <= 1'b1;
        repeat (hold) @(posedge clk);
        acc_done <= 1'b0;
        exp_col++;
        @(negedge clk);
    endtask

    task automatic after_reset();
        @(negedge clk);
        check("w_bank0", w_bank0, '0);
        check("w_bank1", w_bank1, '0);
        check("n_bank0", n_bank0, '0);
        check("n_bank1", n_bank1, '0);
        check("slice_idx", slice_idx, '0);
        check("status", status, '0);
        report_test("reset");
    endtask

    task automatic first_fill();
        for (int i = 0; i < `PP_FILL_DEPTH; i++) begin
            random_gap();
            send_slice(i, 1'b1, 1'b0);
        end
        report_test("first fill");
    endtask

    task automatic swap_and_drain();
        // Bank 1 is idle, so the full bank 0 swaps straight away
        expect_status(1'b1, 1'b1, 1'b0);
        drain_bank = 0;
        exp_k      = 0;
        exp_col    = 0;
        repeat (INNER) step_block();
        step_column(1);
        check("status.draining", status.draining, 1'b1);
        repeat (2) step_block();
        report_test("swap and drain");
    endtask

    task automatic blocked_fill();
        for (int i = 0; i < `PP_FILL_DEPTH; i++) begin
            random_gap();
            send_slice(i, 1'b1, 1'b1);
        end
        // Bank 0 still drains, full bank 1 must wait
        expect_status(1'b1, 1'b1, 1'b1);
        repeat (2) send_slice(`PP_FILL_DEPTH - 1, 1'b0, 1'b1);
        // Second column ends the drain, the pending swap follows one edge later
        step_column(1);
        expect_status(1'b1, 1'b0, 1'b1);
        @(negedge clk);
        expect_status(1'b0, 1'b1, 1'b0);
        drain_bank = 1;
        exp_k      = 0;
        exp_col    = 0;
        report_test("blocked fill");
    endtask

    task automatic held_acc_done();
        step_block();
        // Four edges of a high level count as one column
        step_column(4);
        check("status.draining", status.draining, 1'b1);
        step_block();
        step_column(1);
        expect_status(1'b0, 1'b0, 1'b0);
        report_test("held acc_done");
    endtask

    initial begin
        in_valid        = 1'b0;
        systolic_finish = 1'b0;
        acc_done        = 1'b0;
        while (rst_n !== 1'b1) @(posedge clk);
        after_reset();
        first_fill();
        swap_and_drain();
        blocked_fill();
        held_acc_done();
        $display("tests run: 5, mismatches: %0d", err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
src/pp_pkg.sv
src/pp_fill_gen.sv
src/pp_drain_gen.sv
src/pp_bank_sel.sv
src/pp_bank_route.sv
src/ping_pong_ctrl.sv
verif/tb_clk_gen.sv
verif/tb_ping_pong_ctrl.sv
